// File: build.f
source/aurora_tx_pkg.sv
source/link_ready_filter.sv
source/scan_sequencer.sv
source/frame_builder.sv
source/aurora_64b66b_tx.sv
testbench/tb_fifo_model.sv
testbench/tb_aurora_tx.sv

// File: Makefile
TOP := tb_aurora_tx

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/100ps --top-module $(TOP) -f build.f

# pass only when the pass line shows up in the output
run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q '^Finished with no errors$$'

lint:
	verilator --lint-only --timing --timescale 1ns/100ps --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir

// File: testbench/tb_aurora_tx.sv
module tb_aurora_tx
    import aurora_tx_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DATA_BEATS = 8;
    localparam int FLUSH_WID  = 3;
    localparam logic [TDATA_W-1:0] ENC_BASE = 64'hE000_0000_0000_0000;
    localparam logic [TDATA_W-1:0] FBC_BASE = 64'hF000_0000_0000_0000;
    // three full scans, the aborted start frame, seven data frames
    localparam int TOTAL_BEATS    = 3 * 4 + 2 + 7 * (DATA_BEATS + 1);
    localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 4 + 4 * (2 ** FLUSH_WID) +
                                    LINK_SETTLE_CYCLES + 300;

    logic               USER_CLK = 1'b0;
    logic               RESET;
    logic               CHANNEL_UP;
    logic               pmt_start;
    logic               fbc_start;
    logic               enc_prog_level;
    logic               fbc_prog_level;
    logic               aurora_fbc_empty;
    logic               scan_reset;
    logic               tx_tready = 1'b1;
    logic               random_ready = 1'b0;
    logic [TDATA_W-1:0] enc_head;
    logic [TDATA_W-1:0] fbc_head;
    logic               enc_prog_empty;
    logic               fbc_prog_empty;
    logic               encode_tx_en;
    logic               aurora_fbc_en;
    logic               aurora_scan_end;
    logic               aurora_fbc_end;
    logic               aurora_tx_idle;
    logic [CNT_W-1:0]   encode_pack_cnt;
    logic               tx_tvalid;
    logic [TDATA_W-1:0] tx_tdata;
    logic [KEEP_W-1:0]  tx_tkeep;
    logic               tx_tlast;

    // expected beats with tlast in the top bit
    logic [TDATA_W:0] exp_q[$];
    logic [TDATA_W:0] exp_beat;
    string            test_name = "reset";
    integer           seed = 33;
    int               enc_next = 0;
    int               fbc_next = 0;
    int               enc_rd_cnt = 0;
    int               fbc_rd_cnt = 0;
    int               scan_end_cnt = 0;
    int               fbc_end_cnt = 0;
    int               cycle_cnt = 0;

    always #5 USER_CLK = ~USER_CLK;

    aurora_64b66b_tx #(
        .DATA_BEATS (DATA_BEATS),
        .FLUSH_WID  (FLUSH_WID)
    ) UUT (
        .USER_CLK                (USER_CLK),
        .RESET                   (RESET),
        .CHANNEL_UP              (CHANNEL_UP),
        .pmt_start_en_i          (pmt_start),
        .encode_tx_data_i        (enc_head),
        .encode_tx_prog_empty_i  (enc_prog_empty),
        .encode_tx_en_o          (encode_tx_en),
        .aurora_scan_end_o       (aurora_scan_end),
        .encode_pack_cnt_o       (encode_pack_cnt),
        .fbc_up_start_i          (fbc_start),
        .aurora_fbc_data_i       (fbc_head),
        .aurora_fbc_prog_empty_i (fbc_prog_empty),
        .aurora_fbc_empty_i      (aurora_fbc_empty),
        .aurora_fbc_en_o         (aurora_fbc_en),
        .aurora_fbc_end_o        (aurora_fbc_end),
        .aurora_scan_reset_i     (scan_reset),
        .aurora_tx_idle_o        (aurora_tx_idle),
        .tx_tvalid_o             (tx_tvalid),
        .tx_tdata_o              (tx_tdata),
        .tx_tkeep_o              (tx_tkeep),
        .tx_tlast_o              (tx_tlast),
        .tx_tready_i             (tx_tready)
    );

    tb_fifo_model #(.BASE(ENC_BASE)) u_enc_fifo (
        .USER_CLK     (USER_CLK),
        .RESET        (RESET),
        .rd_en_i      (encode_tx_en),
        .empty_i      (1'b0),
        .prog_level_i (enc_prog_level),
        .head_o       (enc_head),
        .prog_empty_o (enc_prog_empty)
    );

    tb_fifo_model #(.BASE(FBC_BASE)) u_fbc_fifo (
        .USER_CLK     (USER_CLK),
        .RESET        (RESET),
        .rd_en_i      (aurora_fbc_en),
        .empty_i      (aurora_fbc_empty),
        .prog_level_i (fbc_prog_level),
        .head_o       (fbc_head),
        .prog_empty_o (fbc_prog_empty)
    );

    task automatic fail_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [TDATA_W-1:0] exp_val,
                         input logic [TDATA_W-1:0] act_val);
        if (exp_val !== act_val) begin
            $display("[FAIL] %s expected %h actual %h", name, exp_val, act_val);
            fail_run();
        end
    endtask

    ///////////////////////////////////////////////////////////////////////
    // reference model of the beat stream
    ///////////////////////////////////////////////////////////////////////
    function automatic logic [TDATA_W-1:0] expected_beat(input frame_kind_t kind,
                                                         input int idx,
                                                         input logic [TDATA_W-1:0] payload);
        logic [TDATA_W-1:0] beat;
        case (kind)
            KIND_ENC_START: beat = (idx == 0) ? SYNC_HEADER : ENCODE_START_CODE;
            KIND_ENC_END:   beat = (idx == 0) ? SYNC_HEADER : ENCODE_END_CODE;
            KIND_FBC_START: beat = (idx == 0) ? SYNC_HEADER : FBC_START_CODE;
            KIND_FBC_END:   beat = (idx == 0) ? SYNC_HEADER : FBC_END_CODE;
            KIND_ENC_DATA:  beat = (idx == 0) ? ENCODE_DATA_HEADER : payload;
            KIND_FBC_DATA:  beat = (idx == 0) ? FBC_DATA_HEADER : payload;
            default:        beat = '0;
        endcase
        return beat;
    endfunction

    // queue the expected beats of one frame
    // a dry fbc fifo gives zero payload
    task automatic push_frame(input frame_kind_t kind, input logic dry);
        int                 beats;
        logic [TDATA_W-1:0] payload;
        beats = (kind == KIND_ENC_DATA || kind == KIND_FBC_DATA) ? DATA_BEATS + 1 : 2;
        for (int idx = 0; idx < beats; idx++) begin
            payload = '0;
            if (idx > 0 && kind == KIND_ENC_DATA) begin
                payload = ENC_BASE + TDATA_W'(enc_next);
                enc_next++;
            end else if (idx > 0 && kind == KIND_FBC_DATA && !dry) begin
                payload = FBC_BASE + TDATA_W'(fbc_next);
                fbc_next++;
            end
            exp_q.push_back({idx == beats - 1, expected_beat(kind, idx, payload)});
        end
    endtask

    task automatic hold_idle(input int cycles);
        repeat (cycles) begin
            @(negedge USER_CLK);
            check({test_name, " idle"}, 64'd1, TDATA_W'(aurora_tx_idle));
            check({test_name, " tvalid"}, 64'd0, TDATA_W'(tx_tvalid));
        end
    endtask

    // one whole scan with a given number of data frames
    task automatic run_scan(input logic use_fbc, input int frames, input logic dry);
        int scan_before;
        int fbc_before;
        int enc_rd_before;
        int fbc_rd_before;
        scan_before   = scan_end_cnt;
        fbc_before    = fbc_end_cnt;
        enc_rd_before = enc_rd_cnt;
        fbc_rd_before = fbc_rd_cnt;
        push_frame(use_fbc ? KIND_FBC_START : KIND_ENC_START, dry);
        for (int f = 0; f < frames; f++) begin
            push_frame(use_fbc ? KIND_FBC_DATA : KIND_ENC_DATA, dry);
        end
        push_frame(use_fbc ? KIND_FBC_END : KIND_ENC_END, dry);
        @(posedge USER_CLK);
        aurora_fbc_empty <= dry;
        if (use_fbc) begin
            fbc_start      <= 1'b1;
            fbc_prog_level <= 1'b0;
        end else begin
            pmt_start      <= 1'b1;
            enc_prog_level <= 1'b0;
        end
        // last data header gone, so no further data frame is wanted
        while (exp_q.size() > DATA_BEATS + 2) @(posedge USER_CLK);
        pmt_start      <= 1'b0;
        fbc_start      <= 1'b0;
        enc_prog_level <= 1'b1;
        fbc_prog_level <= 1'b1;
        while (scan_end_cnt + fbc_end_cnt == scan_before + fbc_before) @(posedge USER_CLK);
        repeat (2 ** FLUSH_WID) @(posedge USER_CLK);
        @(negedge USER_CLK);
        check({test_name, " beats left"}, 64'd0, TDATA_W'(exp_q.size()));
        check({test_name, " scan end"}, TDATA_W'(!use_fbc), TDATA_W'(scan_end_cnt - scan_before));
        check({test_name, " fbc end"}, TDATA_W'(use_fbc), TDATA_W'(fbc_end_cnt - fbc_before));
        check({test_name, " encode reads"}, TDATA_W'(use_fbc ? 0 : frames * DATA_BEATS),
              TDATA_W'(enc_rd_cnt - enc_rd_before));
        check({test_name, " fbc reads"}, TDATA_W'(use_fbc ? frames * DATA_BEATS : 0),
              TDATA_W'(fbc_rd_cnt - fbc_rd_before));
        check({test_name, " idle"}, 64'd1, TDATA_W'(aurora_tx_idle));
    endtask

    ///////////////////////////////////////////////////////////////////////
    // compare, counters, back-pressure, timeout
    ///////////////////////////////////////////////////////////////////////
    always @(negedge USER_CLK) begin
        if (!RESET && tx_tvalid && tx_tready) begin
            if (exp_q.size() == 0) begin
                $display("%s: a beat %h was sent when none was expected", test_name, tx_tdata);
                fail_run();
            end else begin
                exp_beat = exp_q.pop_front();
                check({test_name, " tdata"}, exp_beat[TDATA_W-1:0], tx_tdata);
                check({test_name, " tlast"}, TDATA_W'(exp_beat[TDATA_W]), TDATA_W'(tx_tlast));
                check({test_name, " tkeep"}, 64'hFF, TDATA_W'(tx_tkeep));
            end
        end
        if (encode_tx_en) enc_rd_cnt++;
        if (aurora_fbc_en) fbc_rd_cnt++;
        if (aurora_scan_end) scan_end_cnt++;
        if (aurora_fbc_end) fbc_end_cnt++;
    end

    // ready about three cycles in four
    always @(posedge USER_CLK) begin
        tx_tready <= random_ready ? (($random(seed) % 4) != 0) : 1'b1;
    end

    always @(posedge USER_CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("%s: the run did not finish within %0d cycles", test_name, TIMEOUT_CYCLES);
            fail_run();
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // stimulus
    ///////////////////////////////////////////////////////////////////////
    initial begin
        int ends_before;
        RESET            = 1'b1;
        CHANNEL_UP       = 1'b0;
        pmt_start        = 1'b0;
        fbc_start        = 1'b0;
        enc_prog_level   = 1'b1;
        fbc_prog_level   = 1'b1;
        aurora_fbc_empty = 1'b0;
        scan_reset       = 1'b0;
        repeat (5) @(posedge USER_CLK);
        RESET <= 1'b0;

        // link down, then up too briefly to qualify
        test_name = "link_down";
        @(posedge USER_CLK);
        pmt_start <= 1'b1;
        hold_idle(30);
        @(posedge USER_CLK);
        CHANNEL_UP <= 1'b1;
        hold_idle(10);
        @(posedge USER_CLK);
        CHANNEL_UP <= 1'b0;
        hold_idle(10);
        @(posedge USER_CLK);
        pmt_start <= 1'b0;
        hold_idle(4);
        @(posedge USER_CLK);
        CHANNEL_UP <= 1'b1;
        hold_idle(LINK_SETTLE_CYCLES + 4);

        test_name = "encode_scan";
        run_scan(1'b0, 2, 1'b0);
        check("encode_scan pack count", 64'd2, TDATA_W'(encode_pack_cnt));

        test_name = "fbc_dry_scan";
        run_scan(1'b1, 2, 1'b1);

        test_name = "fbc_backpressure";
        @(posedge USER_CLK);
        random_ready <= 1'b1;
        run_scan(1'b1, 3, 1'b0);
        @(posedge USER_CLK);
        random_ready <= 1'b0;
        // fbc frames leave the encode count alone
        check("fbc_backpressure pack count", 64'd2, TDATA_W'(encode_pack_cnt));

        // abort while waiting for data
        test_name   = "scan_reset";
        ends_before = scan_end_cnt + fbc_end_cnt;
        push_frame(KIND_ENC_START, 1'b0);
        @(posedge USER_CLK);
        pmt_start <= 1'b1;
        while (exp_q.size() != 0) @(posedge USER_CLK);
        repeat (4) @(posedge USER_CLK);
        @(negedge USER_CLK);
        check("scan_reset busy", 64'd0, TDATA_W'(aurora_tx_idle));
        // a new encode scan clears the count
        check("scan_reset pack count", 64'd0, TDATA_W'(encode_pack_cnt));
        @(posedge USER_CLK);
        pmt_start  <= 1'b0;
        scan_reset <= 1'b1;
        repeat (4) @(posedge USER_CLK);
        scan_reset <= 1'b0;
        hold_idle(2 ** FLUSH_WID + 8);
        check("scan_reset end pulses", TDATA_W'(ends_before),
              TDATA_W'(scan_end_cnt + fbc_end_cnt));

        if (exp_q.size() == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("%0d expected beats were never sent", exp_q.size());
            fail_run();
        end
    end

endmodule

// File: testbench/tb_fifo_model.sv
module tb_fifo_model
    import aurora_tx_pkg::*;
#(
    parameter logic [TDATA_W-1:0] BASE = '0
) (
    input  logic               USER_CLK,
    input  logic               RESET,
    input  logic               rd_en_i,
    input  logic               empty_i,
    input  logic               prog_level_i,
    output logic [TDATA_W-1:0] head_o,
    output logic               prog_empty_o
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [TDATA_W-1:0] pop_cnt_q;

    // an empty fifo ignores reads
    always_ff @(posedge USER_CLK) begin
        if (RESET) begin
            pop_cnt_q <= '0;
        end else if (rd_en_i && !empty_i) begin
            pop_cnt_q <= pop_cnt_q + 1'b1;
        end
    end

    // first word fall through, head is always the next unread word
    assign head_o       = BASE + pop_cnt_q;
    assign prog_empty_o = prog_level_i;

endmodule

// File: source/aurora_64b66b_tx.sv
module aurora_64b66b_tx
    import aurora_tx_pkg::*;
#(
    parameter int DATA_BEATS = 512,
    parameter int FLUSH_WID  = 8
) (
    input  logic               USER_CLK,
    input  logic               RESET,
    input  logic               CHANNEL_UP,

    // pmt encode source
    input  logic               pmt_start_en_i,
    input  logic [TDATA_W-1:0] encode_tx_data_i,
    input  logic               encode_tx_prog_empty_i,
    output logic               encode_tx_en_o,
    output logic               aurora_scan_end_o,
    output logic [CNT_W-1:0]   encode_pack_cnt_o,

    // fbc source
    input  logic               fbc_up_start_i,
    input  logic [TDATA_W-1:0] aurora_fbc_data_i,
    input  logic               aurora_fbc_prog_empty_i,
    input  logic               aurora_fbc_empty_i,
    output logic               aurora_fbc_en_o,
    output logic               aurora_fbc_end_o,

    input  logic               aurora_scan_reset_i,
    output logic               aurora_tx_idle_o,

    // aurora user tx stream
    output logic               tx_tvalid_o,
    output logic [TDATA_W-1:0] tx_tdata_o,
    output logic [KEEP_W-1:0]  tx_tkeep_o,
    output logic               tx_tlast_o,
    input  logic               tx_tready_i
);

    logic        link_ok;
    logic        frame_start;
    frame_kind_t frame_kind;
    logic        frame_done;

    link_ready_filter u_link_ready_filter (
        .USER_CLK     (USER_CLK),
        .RESET        (RESET),
        .channel_up_i (CHANNEL_UP),
        .link_ok_o    (link_ok)
    );

    scan_sequencer #(
        .FLUSH_WID (FLUSH_WID)
    ) u_scan_sequencer (
        .USER_CLK            (USER_CLK),
        .RESET               (RESET),
        .link_ok_i           (link_ok),
        .scan_reset_i        (aurora_scan_reset_i),
        .pmt_start_en_i      (pmt_start_en_i),
        .fbc_up_start_i      (fbc_up_start_i),
        .encode_prog_empty_i (encode_tx_prog_empty_i),
        .fbc_prog_empty_i    (aurora_fbc_prog_empty_i),
        .frame_done_i        (frame_done),
        .frame_start_o       (frame_start),
        .frame_kind_o        (frame_kind),
        .tx_idle_o           (aurora_tx_idle_o),
        .scan_end_o          (aurora_scan_end_o),
        .fbc_end_o           (aurora_fbc_end_o),
        .encode_pack_cnt_o   (encode_pack_cnt_o)
    );

    frame_builder #(
        .DATA_BEATS (DATA_BEATS)
    ) u_frame_builder (
        .USER_CLK       (USER_CLK),
        .RESET          (RESET),
        .frame_start_i  (frame_start),
        .frame_kind_i   (frame_kind),
        .encode_data_i  (encode_tx_data_i),
        .fbc_data_i     (aurora_fbc_data_i),
        .fbc_empty_i    (aurora_fbc_empty_i),
        .tx_tready_i    (tx_tready_i),
        .frame_done_o   (frame_done),
        .encode_rd_en_o (encode_tx_en_o),
        .fbc_rd_en_o    (aurora_fbc_en_o),
        .tx_tvalid_o    (tx_tvalid_o),
        .tx_tlast_o     (tx_tlast_o),
        .tx_tdata_o     (tx_tdata_o)
    );

    // every beat carries all eight bytes
    assign tx_tkeep_o = '1;

endmodule

// File: source/frame_builder.sv
module frame_builder
    import aurora_tx_pkg::*;
#(
    parameter int DATA_BEATS = 512
) (
    input  logic               USER_CLK,
    input  logic               RESET,
    input  logic               frame_start_i,
    input  frame_kind_t        frame_kind_i,
    input  logic [TDATA_W-1:0] encode_data_i,
    input  logic [TDATA_W-1:0] fbc_data_i,
    input  logic               fbc_empty_i,
    input  logic               tx_tready_i,
    output logic               frame_done_o,
    output logic               encode_rd_en_o,
    output logic               fbc_rd_en_o,
    output logic               tx_tvalid_o,
    output logic               tx_tlast_o,
    output logic [TDATA_W-1:0] tx_tdata_o
);

    localparam logic [BEAT_CNT_W-1:0] DATA_LAST = BEAT_CNT_W'(DATA_BEATS);

    frame_kind_t            kind_q;
    logic [BEAT_CNT_W-1:0]  beat_idx_q;
    logic [BEAT_CNT_W-1:0]  last_idx;
    logic                   is_data;
    logic                   is_header;
    logic                   accept;

    // kind is captured once per frame
    always_ff @(posedge USER_CLK) begin
        if (frame_start_i) begin
            kind_q <= frame_kind_i;
        end
    end

    assign is_data   = (kind_q == KIND_ENC_DATA) || (kind_q == KIND_FBC_DATA);
    assign is_header = (beat_idx_q == '0);
    // control frames are two beats, data frames a header plus payload
    assign last_idx  = is_data ? DATA_LAST : BEAT_CNT_W'(1);
    assign accept    = tx_tvalid_o && tx_tready_i;

    ///////////////////////////////////////////////////////////////////////
    // beat index and valid
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge USER_CLK) begin
        if (RESET) begin
            tx_tvalid_o <= 1'b0;
            beat_idx_q  <= '0;
        end else if (frame_start_i) begin
            tx_tvalid_o <= 1'b1;
            beat_idx_q  <= '0;
        end else if (accept) begin
            if (tx_tlast_o) begin
                tx_tvalid_o <= 1'b0;
                beat_idx_q  <= '0;
            end else begin
                beat_idx_q <= beat_idx_q + 1'b1;
            end
        end
    end

    assign tx_tlast_o   = tx_tvalid_o && (beat_idx_q == last_idx);
    assign frame_done_o = accept && tx_tlast_o;

    ///////////////////////////////////////////////////////////////////////
    // beat data
    ///////////////////////////////////////////////////////////////////////
    always_comb begin
        case (kind_q)
            KIND_ENC_START: tx_tdata_o = is_header ? SYNC_HEADER : ENCODE_START_CODE;
            KIND_ENC_END:   tx_tdata_o = is_header ? SYNC_HEADER : ENCODE_END_CODE;
            KIND_FBC_START: tx_tdata_o = is_header ? SYNC_HEADER : FBC_START_CODE;
            KIND_FBC_END:   tx_tdata_o = is_header ? SYNC_HEADER : FBC_END_CODE;
            KIND_ENC_DATA:  tx_tdata_o = is_header ? ENCODE_DATA_HEADER : encode_data_i;
            KIND_FBC_DATA: begin
                if (is_header) begin
                    tx_tdata_o = FBC_DATA_HEADER;
                end else if (fbc_empty_i) begin
                    // fifo ran dry, pad with zero
                    tx_tdata_o = '0;
                end else begin
                    tx_tdata_o = fbc_data_i;
                end
            end
            default:        tx_tdata_o = '0;
        endcase
    end

    // pop the fifo head as each payload beat goes out
    assign encode_rd_en_o = accept && !is_header && (kind_q == KIND_ENC_DATA);
    assign fbc_rd_en_o    = accept && !is_header && (kind_q == KIND_FBC_DATA);

endmodule

// File: source/scan_sequencer.sv
module scan_sequencer
    import aurora_tx_pkg::*;
#(
    parameter int FLUSH_WID = 8
) (
    input  logic             USER_CLK,
    input  logic             RESET,
    input  logic             link_ok_i,
    input  logic             scan_reset_i,
    input  logic             pmt_start_en_i,
    input  logic             fbc_up_start_i,
    input  logic             encode_prog_empty_i,
    input  logic             fbc_prog_empty_i,
    input  logic             frame_done_i,
    output logic             frame_start_o,
    output frame_kind_t      frame_kind_o,
    output logic             tx_idle_o,
    output logic             scan_end_o,
    output logic             fbc_end_o,
    output logic [CNT_W-1:0] encode_pack_cnt_o
);

    seq_state_t             state_q;
    seq_state_t             state_d;
    logic                   owner_fbc_q;
    logic                   owner_fbc_d;
    logic [1:0]             pmt_sync_q;
    logic [1:0]             fbc_sync_q;
    logic [FLUSH_WID-1:0]   flush_cnt_q;
    logic                   frame_busy_q;
    logic                   abort;
    logic                   start_lvl;
    logic                   prog_empty;
    logic                   flush_last;
    logic                   flush_exit;
    logic                   enter_frame;

    ///////////////////////////////////////////////////////////////////////
    // start level synchronisers
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge USER_CLK) begin
        if (RESET) begin
            pmt_sync_q <= '0;
            fbc_sync_q <= '0;
        end else begin
            pmt_sync_q <= {pmt_sync_q[0], pmt_start_en_i};
            fbc_sync_q <= {fbc_sync_q[0], fbc_up_start_i};
        end
    end

    // level and fill flag of whichever source owns the scan
    assign start_lvl  = owner_fbc_q ? fbc_sync_q[1] : pmt_sync_q[1];
    assign prog_empty = owner_fbc_q ? fbc_prog_empty_i : encode_prog_empty_i;
    assign abort      = !link_ok_i || scan_reset_i;
    assign flush_last = &flush_cnt_q;
    assign flush_exit = (state_q == ST_FLUSH) && flush_last && !abort;

    ///////////////////////////////////////////////////////////////////////
    // next state
    ///////////////////////////////////////////////////////////////////////
    always_comb begin
        state_d     = state_q;
        owner_fbc_d = owner_fbc_q;
        case (state_q)
            ST_IDLE: begin
                // wait for an aborted frame to drain first
                if (!frame_busy_q) begin
                    if (pmt_sync_q[1]) begin
                        state_d     = ST_START;
                        owner_fbc_d = 1'b0;
                    end else if (fbc_sync_q[1]) begin
                        state_d     = ST_START;
                        owner_fbc_d = 1'b1;
                    end
                end
            end
            ST_START: if (frame_done_i) state_d = ST_WAIT;
            ST_WAIT: begin
                if (!start_lvl) begin
                    state_d = ST_END;
                end else if (!prog_empty) begin
                    state_d = ST_DATA;
                end
            end
            ST_DATA:  if (frame_done_i) state_d = ST_WAIT;
            ST_END:   if (frame_done_i) state_d = ST_FLUSH;
            ST_FLUSH: if (flush_last) state_d = ST_IDLE;
            default:  state_d = ST_IDLE;
        endcase
        if (abort) begin
            state_d = ST_IDLE;
        end
    end

    assign enter_frame = (state_d != state_q) &&
                         (state_d == ST_START || state_d == ST_DATA || state_d == ST_END);

    always_ff @(posedge USER_CLK) begin
        if (RESET) begin
            state_q       <= ST_IDLE;
            owner_fbc_q   <= 1'b0;
            frame_start_o <= 1'b0;
            frame_busy_q  <= 1'b0;
        end else begin
            state_q       <= state_d;
            owner_fbc_q   <= owner_fbc_d;
            frame_start_o <= enter_frame;
            if (frame_start_o) begin
                frame_busy_q <= 1'b1;
            end else if (frame_done_i) begin
                frame_busy_q <= 1'b0;
            end
        end
    end

    always_comb begin
        case (state_q)
            ST_START: frame_kind_o = owner_fbc_q ? KIND_FBC_START : KIND_ENC_START;
            ST_END:   frame_kind_o = owner_fbc_q ? KIND_FBC_END : KIND_ENC_END;
            default:  frame_kind_o = owner_fbc_q ? KIND_FBC_DATA : KIND_ENC_DATA;
        endcase
    end

    ///////////////////////////////////////////////////////////////////////
    // flush pause, end pulses, frame counter
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge USER_CLK) begin
        if (RESET) begin
            flush_cnt_q       <= '0;
            scan_end_o        <= 1'b0;
            fbc_end_o         <= 1'b0;
            encode_pack_cnt_o <= '0;
        end else begin
            if (state_q == ST_FLUSH) begin
                flush_cnt_q <= flush_cnt_q + 1'b1;
            end else begin
                flush_cnt_q <= '0;
            end
            scan_end_o <= flush_exit && !owner_fbc_q;
            fbc_end_o  <= flush_exit && owner_fbc_q;
            // encode data frames only, cleared when an encode scan opens
            if (state_q == ST_IDLE && state_d == ST_START && !owner_fbc_d) begin
                encode_pack_cnt_o <= '0;
            end else if (state_q == ST_WAIT && state_d == ST_DATA && !owner_fbc_q &&
                         !encode_pack_cnt_o[CNT_W-1]) begin
                encode_pack_cnt_o <= encode_pack_cnt_o + 1'b1;
            end
        end
    end

    assign tx_idle_o = (state_q == ST_IDLE);

endmodule

// File: source/link_ready_filter.sv
module link_ready_filter
    import aurora_tx_pkg::*;
(
    input  logic USER_CLK,
    input  logic RESET,
    input  logic channel_up_i,
    output logic link_ok_o
);

    localparam int SETTLE_W = $clog2(LINK_SETTLE_CYCLES + 1);
    localparam logic [SETTLE_W-1:0] SETTLE_MAX = SETTLE_W'(LINK_SETTLE_CYCLES);

    logic [SETTLE_W-1:0] up_cnt_q;

    // saturating count of consecutive channel-up cycles
    always_ff @(posedge USER_CLK) begin
        if (RESET) begin
            up_cnt_q <= '0;
        end else if (!channel_up_i) begin
            up_cnt_q <= '0;
        end else if (up_cnt_q != SETTLE_MAX) begin
            up_cnt_q <= up_cnt_q + 1'b1;
        end
    end

    assign link_ok_o = (up_cnt_q == SETTLE_MAX);

endmodule

// File: source/aurora_tx_pkg.sv
package aurora_tx_pkg;

    ///////////////////////////////////////////////////////////////////////
    // stream widths
    ///////////////////////////////////////////////////////////////////////
    localparam int TDATA_W    = 64;
    localparam int KEEP_W     = 8;
    localparam int CNT_W      = 32;
    localparam int BEAT_CNT_W = 16;

    ///////////////////////////////////////////////////////////////////////
    // frame headers and control codes
    ///////////////////////////////////////////////////////////////////////
    localparam logic [TDATA_W-1:0] SYNC_HEADER        = 64'h0000_0000_55AA_0001;
    localparam logic [TDATA_W-1:0] ENCODE_DATA_HEADER = 64'h0000_0000_55AA_0003;
    localparam logic [TDATA_W-1:0] FBC_DATA_HEADER    = 64'h0000_0000_55AA_0004;

    localparam logic [TDATA_W-1:0] ENCODE_START_CODE  = 64'd4;
    localparam logic [TDATA_W-1:0] ENCODE_END_CODE    = 64'd5;
    localparam logic [TDATA_W-1:0] FBC_START_CODE     = 64'd2;
    localparam logic [TDATA_W-1:0] FBC_END_CODE       = 64'd3;

    // stable CHANNEL_UP cycles before the link is used
    localparam int LINK_SETTLE_CYCLES = 16;

    typedef enum logic [2:0] {
        KIND_ENC_START,
        KIND_ENC_DATA,
        KIND_ENC_END,
        KIND_FBC_START,
        KIND_FBC_DATA,
        KIND_FBC_END
    } frame_kind_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_WAIT,
        ST_DATA,
        ST_END,
        ST_FLUSH
    } seq_state_t;

endpackage
